// File: files.f
hw/pmp_pkg.sv
hw/pmp_chk_if.sv
hw/pmp_csr_regs.sv
hw/pmp_region_check.sv
hw/pmp_fault_log.sv
hw/pmp_top.sv
verif/tb_clk_gen.sv
verif/pmp_tb.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing -Wno-fatal
TOP       := pmp_tb
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BUILD_DIR)/V%: $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $* -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/pmp_tb.sv
// ----------------------------------------------------------------------
// PMP unit testbench
// Table of CSR writes, reads, accesses and fault clears with checks
// ----------------------------------------------------------------------

`timescale 1ns/10ps

module pmp_tb import pmp_pkg::*; ();

  localparam int CLK_PERIOD  = 100;
  localparam int TIMEOUT_CYC = 20;
  localparam int RSP_LATENCY = 2;
  localparam int N_PROBES    = 16;
  localparam int SEED        = 88;
  localparam csr_addr_t CSR_PMPCFG1 = CSR_PMPCFG0 + 12'd1;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_ACC, OP_CLR, OP_FLT} op_t;

  // Fields used by a table row depend on its operation
  typedef struct packed {
    op_t                                 kind;
    csr_addr_t                           csr;
    // Write data, expected read data or expected fault address
    logic [31:0]                         data;
    logic [PMP_CHANNELS-1:0]             vld;
    logic [PMP_CHANNELS-1:0]             priv;
    logic [PMP_CHANNELS-1:0][ADDR_W-1:0] addr;
    acc_type_t                           typ0;
    acc_type_t                           typ1;
    logic [PMP_CHANNELS-1:0]             err;
    logic                                pend;
    chan_idx_t                           chan;
    // Next row follows in the very next cycle
    logic                                back;
  } row_t;

  // Expected response of one outstanding request
  typedef struct packed {
    logic [PMP_CHANNELS-1:0] vld;
    logic [PMP_CHANNELS-1:0] err;
    logic [63:0]             t_issue;
  } rsp_exp_t;

  logic                                clk;
  logic                                rst_i;
  logic                                csr_we_i;
  csr_addr_t                           csr_addr_i;
  logic [31:0]                         csr_wdata_i;
  logic [31:0]                         csr_rdata_o;
  logic [PMP_CHANNELS-1:0]             req_valid_i;
  logic [PMP_CHANNELS-1:0][ADDR_W-1:0] req_addr_i;
  acc_type_t                           req_type_i [PMP_CHANNELS];
  logic [PMP_CHANNELS-1:0]             req_priv_i;
  logic [PMP_CHANNELS-1:0]             rsp_valid_o;
  logic [PMP_CHANNELS-1:0]             rsp_err_o;
  logic                                fault_clr_i;
  logic                                fault_pending_o;
  logic [ADDR_W-1:0]                   fault_addr_o;
  acc_type_t                           fault_type_o;
  chan_idx_t                           fault_chan_o;

  row_t        rows [$];
  rsp_exp_t    exp_q [$];
  rsp_exp_t    rsp_exp;
  logic [63:0] lat_cyc;
  int          n_checks   = 0;
  int          n_errors   = 0;
  int          n_other    = 0;
  int          n_timeouts = 0;

  tb_clk_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst_i)
  );

  pmp_top DUT (
    .clk             (clk),
    .rst_i           (rst_i),
    .csr_we_i        (csr_we_i),
    .csr_addr_i      (csr_addr_i),
    .csr_wdata_i     (csr_wdata_i),
    .csr_rdata_o     (csr_rdata_o),
    .req_valid_i     (req_valid_i),
    .req_addr_i      (req_addr_i),
    .req_type_i      (req_type_i),
    .req_priv_i      (req_priv_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_err_o       (rsp_err_o),
    .fault_clr_i     (fault_clr_i),
    .fault_pending_o (fault_pending_o),
    .fault_addr_o    (fault_addr_o),
    .fault_type_o    (fault_type_o),
    .fault_chan_o    (fault_chan_o)
  );

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------

  task automatic check_err(input string name, input logic [PMP_CHANNELS-1:0] exp,
                           input logic [PMP_CHANNELS-1:0] act);
    n_checks++;
    if (act !== exp) begin
      $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
      n_errors++;
    end
  endtask

  task automatic check_valid(input logic [PMP_CHANNELS-1:0] exp,
                             input logic [PMP_CHANNELS-1:0] act);
    n_checks++;
    if (act !== exp) begin
      $display("ERROR at %0t: rsp_valid_o expected %b, got %b", $time, exp, act);
      n_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      $display("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act);
      n_errors++;
    end
  endtask

  task automatic check_word(input string name, input pmp_addr_t exp, input pmp_addr_t act);
    n_checks++;
    if (act !== exp) begin
      $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
      n_errors++;
    end
  endtask

  task automatic check_type(input string name, input acc_type_t exp, input acc_type_t act);
    n_checks++;
    if (act !== exp) begin
      $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      n_errors++;
    end
  endtask

  task automatic check_chan(input string name, input chan_idx_t exp, input chan_idx_t act);
    n_checks++;
    if (act !== exp) begin
      $display("ERROR at %0t: %s expected %0d, got %0d", $time, name, exp, act);
      n_errors++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Table rows
  // ----------------------------------------------------------------------

  function automatic csr_addr_t pmpaddr_csr(input int e);
    return csr_addr_t'(CSR_PMPADDR0 + e);
  endfunction

  // CSR write, or CSR read with its expected data
  function automatic void add_csr(input op_t kind, input csr_addr_t a, input logic [31:0] d);
    row_t rw;
    rw      = '0;
    rw.kind = kind;
    rw.csr  = a;
    rw.data = d;
    rows.push_back(rw);
  endfunction

  function automatic void add_acc(input chan_idx_t c, input logic user, input logic [31:0] a,
                                  input acc_type_t t, input logic deny, input logic back);
    row_t rw;
    rw         = '0;
    rw.kind    = OP_ACC;
    rw.vld[c]  = 1'b1;
    rw.priv[c] = user;
    rw.addr[c] = a;
    rw.err[c]  = deny;
    rw.back    = back;
    if (c == 0) begin
      rw.typ0 = t;
    end else begin
      rw.typ1 = t;
    end
    rows.push_back(rw);
  endfunction

  // User-mode requests on both channels in the same cycle
  function automatic void add_pair(input logic [31:0] a0, input acc_type_t t0,
                                   input logic [31:0] a1, input acc_type_t t1,
                                   input logic [1:0] deny, input logic back);
    row_t rw;
    rw      = '0;
    rw.kind = OP_ACC;
    rw.vld  = 2'b11;
    rw.priv = 2'b11;
    rw.addr = {a1, a0};
    rw.typ0 = t0;
    rw.typ1 = t1;
    rw.err  = deny;
    rw.back = back;
    rows.push_back(rw);
  endfunction

  function automatic void add_op(input op_t kind);
    row_t rw;
    rw      = '0;
    rw.kind = kind;
    rows.push_back(rw);
  endfunction

  function automatic void add_flt(input logic pend, input logic [31:0] a,
                                  input acc_type_t t, input chan_idx_t c);
    row_t rw;
    rw      = '0;
    rw.kind = OP_FLT;
    rw.pend = pend;
    rw.data = a;
    rw.typ0 = t;
    rw.chan = c;
    rows.push_back(rw);
  endfunction

  // User-mode verdict for the TOR, NA4 and NAPOT regions
  // Regions are RX [0x1000,0x2000), RW [0x3000,0x3004), X [0x4000,0x4100)
  function automatic logic probe_denied(input logic [31:0] a, input acc_type_t t);
    logic [2:0] rwx;
    if (a >= 32'h1000 && a < 32'h2000) begin
      rwx = 3'b101;
    end else if (a >= 32'h3000 && a < 32'h3004) begin
      rwx = 3'b011;
    end else if (a >= 32'h4000 && a < 32'h4100) begin
      rwx = 3'b100;
    end else begin
      // No match with active entries
      return 1'b1;
    end
    return !rwx[t];
  endfunction

  task automatic build_table();
    logic [31:0] a;
    logic [31:0] fill;
    acc_type_t   t;
    chan_idx_t   c;
    // All entries are OFF after reset
    add_csr(OP_RD, CSR_PMPCFG0, 32'h0);
    add_csr(OP_RD, CSR_PMPCFG1, 32'h0);
    add_csr(OP_RD, pmpaddr_csr(0), 32'h0);
    add_csr(OP_RD, CSR_PMPCFG0 + 12'd2, 32'h0);
    add_flt(1'b0, 32'h0, ACC_READ, 1'b0);
    add_acc(1'b0, 1'b0, 32'h0000_1000, ACC_EXEC, 1'b0, 1'b0);
    add_acc(1'b1, 1'b1, 32'h0000_2000, ACC_READ, 1'b0, 1'b0);
    add_acc(1'b1, 1'b1, 32'h8000_0000, ACC_WRITE, 1'b0, 1'b0);

    // TOR RX on entry 1, NA4 RW on entry 2, NAPOT X on entry 3
    add_csr(OP_WR, pmpaddr_csr(0), 32'h0000_0400);
    add_csr(OP_WR, pmpaddr_csr(1), 32'h0000_0800);
    add_csr(OP_WR, pmpaddr_csr(2), 32'h0000_0C00);
    add_csr(OP_WR, pmpaddr_csr(3), 32'h0000_101F);
    add_csr(OP_WR, CSR_PMPCFG0, 32'h1C13_0D00);
    add_csr(OP_RD, CSR_PMPCFG0, 32'h1C13_0D00);
    add_csr(OP_RD, pmpaddr_csr(3), 32'h0000_101F);
    for (int e = 6; e < 8; e++) begin
      fill = $urandom;
      add_csr(OP_WR, pmpaddr_csr(e), fill);
      add_csr(OP_RD, pmpaddr_csr(e), fill);
    end
    add_acc(1'b1, 1'b1, 32'h0000_1000, ACC_READ, 1'b0, 1'b0);
    add_acc(1'b1, 1'b1, 32'h0000_1FFC, ACC_READ, 1'b0, 1'b0);
    add_acc(1'b1, 1'b1, 32'h0000_2000, ACC_READ, 1'b1, 1'b0);
    add_flt(1'b1, 32'h0000_2000, ACC_READ, 1'b1);
    add_acc(1'b1, 1'b1, 32'h0000_0FFC, ACC_READ, 1'b1, 1'b0);
    add_acc(1'b1, 1'b1, 32'h0000_1800, ACC_WRITE, 1'b1, 1'b0);
    add_acc(1'b0, 1'b1, 32'h0000_1800, ACC_EXEC, 1'b0, 1'b0);
    add_acc(1'b1, 1'b1, 32'h0000_3000, ACC_WRITE, 1'b0, 1'b0);
    add_acc(1'b1, 1'b1, 32'h0000_3003, ACC_READ, 1'b0, 1'b0);
    add_acc(1'b1, 1'b1, 32'h0000_3004, ACC_READ, 1'b1, 1'b0);
    add_acc(1'b1, 1'b1, 32'h0000_2FFC, ACC_READ, 1'b1, 1'b0);
    add_acc(1'b0, 1'b1, 32'h0000_3000, ACC_EXEC, 1'b1, 1'b0);
    add_acc(1'b0, 1'b1, 32'h0000_4000, ACC_EXEC, 1'b0, 1'b0);
    add_acc(1'b0, 1'b1, 32'h0000_40FC, ACC_EXEC, 1'b0, 1'b0);
    add_acc(1'b0, 1'b1, 32'h0000_4100, ACC_EXEC, 1'b1, 1'b0);
    add_acc(1'b0, 1'b1, 32'h0000_3FFC, ACC_EXEC, 1'b1, 1'b0);
    add_acc(1'b1, 1'b1, 32'h0000_4080, ACC_READ, 1'b1, 1'b0);
    // Machine mode passes on unlocked entries and on no match
    add_acc(1'b1, 1'b0, 32'h0000_2000, ACC_WRITE, 1'b0, 1'b0);
    add_acc(1'b1, 1'b0, 32'h0000_1800, ACC_WRITE, 1'b0, 1'b0);
    for (int i = 0; i < N_PROBES; i++) begin
      a = 32'h0000_0F00 + ($urandom % 32'h3400);
      t = acc_type_t'($urandom % 3);
      c = chan_idx_t'($urandom % 2);
      add_acc(c, 1'b1, a, t, probe_denied(a, t), 1'b0);
    end

    // Overlapping NAPOT entries 4 (R, 256 B) and 5 (RW, 4 KB) at 0x8000
    add_csr(OP_WR, pmpaddr_csr(4), 32'h0000_201F);
    add_csr(OP_WR, pmpaddr_csr(5), 32'h0000_21FF);
    add_csr(OP_WR, pmpaddr_csr(6), 32'h0000_2800);
    add_csr(OP_WR, CSR_PMPCFG1, 32'h0000_1B19);
    add_acc(1'b1, 1'b1, 32'h0000_8010, ACC_WRITE, 1'b1, 1'b0);
    add_acc(1'b1, 1'b1, 32'h0000_8800, ACC_WRITE, 1'b0, 1'b0);
    add_acc(1'b1, 1'b1, 32'h0000_8010, ACC_READ, 1'b0, 1'b0);
    add_acc(1'b1, 1'b0, 32'h0000_8010, ACC_WRITE, 1'b0, 1'b0);
    // Lock entry 4 and a TOR X entry 6 on top of entry 5
    add_csr(OP_WR, CSR_PMPCFG1, 32'h008C_1B99);
    add_csr(OP_RD, CSR_PMPCFG1, 32'h008C_1B99);
    add_acc(1'b1, 1'b0, 32'h0000_8010, ACC_WRITE, 1'b1, 1'b0);
    add_acc(1'b1, 1'b0, 32'h0000_8010, ACC_READ, 1'b0, 1'b0);
    add_acc(1'b1, 1'b0, 32'h0000_9000, ACC_READ, 1'b1, 1'b0);
    add_acc(1'b0, 1'b0, 32'h0000_9000, ACC_EXEC, 1'b0, 1'b0);
    add_acc(1'b0, 1'b1, 32'h0000_9000, ACC_EXEC, 1'b0, 1'b0);
    add_csr(OP_WR, pmpaddr_csr(4), 32'hFFFF_FFFF);
    add_csr(OP_RD, pmpaddr_csr(4), 32'h0000_201F);
    add_csr(OP_WR, pmpaddr_csr(5), 32'h0000_1234);
    add_csr(OP_RD, pmpaddr_csr(5), 32'h0000_21FF);
    add_csr(OP_WR, pmpaddr_csr(6), 32'h0);
    add_csr(OP_RD, pmpaddr_csr(6), 32'h0000_2800);
    // Only the unlocked byte of entry 5 changes
    add_csr(OP_WR, CSR_PMPCFG1, 32'h0000_1F00);
    add_csr(OP_RD, CSR_PMPCFG1, 32'h008C_1F99);

    // Entry 7 drops W without R and the reserved bits
    add_csr(OP_WR, CSR_PMPCFG1, 32'h6600_1F00);
    add_csr(OP_RD, CSR_PMPCFG1, 32'h048C_1F99);
    add_csr(OP_WR, CSR_PMPCFG1, 32'h6300_1F00);
    add_csr(OP_RD, CSR_PMPCFG1, 32'h038C_1F99);

    // First fault still held after later ones
    add_flt(1'b1, 32'h0000_2000, ACC_READ, 1'b1);
    add_op(OP_CLR);
    add_flt(1'b0, 32'h0000_2000, ACC_READ, 1'b1);
    // A tie and two more faults back to back
    add_pair(32'h0000_5000, ACC_EXEC, 32'h0000_6000, ACC_READ, 2'b11, 1'b1);
    add_acc(1'b1, 1'b1, 32'h0000_1800, ACC_WRITE, 1'b1, 1'b1);
    add_acc(1'b0, 1'b1, 32'h0000_4100, ACC_EXEC, 1'b1, 1'b0);
    add_flt(1'b1, 32'h0000_5000, ACC_EXEC, 1'b0);
    add_op(OP_CLR);
    add_flt(1'b0, 32'h0000_5000, ACC_EXEC, 1'b0);
    add_acc(1'b1, 1'b1, 32'h0000_3004, ACC_WRITE, 1'b1, 1'b0);
    add_flt(1'b1, 32'h0000_3004, ACC_WRITE, 1'b1);
    // Fault reaches the log in the same cycle as the clear
    add_acc(1'b0, 1'b1, 32'h0000_2000, ACC_READ, 1'b1, 1'b1);
    add_op(OP_CLR);
    add_flt(1'b1, 32'h0000_2000, ACC_READ, 1'b0);
  endtask

  // ----------------------------------------------------------------------
  // Driving and waiting
  // ----------------------------------------------------------------------

  task automatic drive_idle();
    csr_we_i    <= 1'b0;
    req_valid_i <= '0;
    fault_clr_i <= 1'b0;
  endtask

  // Wait until every issued request has been answered
  task automatic drain_responses();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n_timeouts == 0) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT_CYC) begin
        $display("Timeout at %0t: %0d responses missing after %0d cycles",
                 $time, exp_q.size(), TIMEOUT_CYC);
        n_timeouts++;
      end
    end
  endtask

  task automatic apply_row(input row_t rw);
    rsp_exp_t ex;
    @(posedge clk);
    drive_idle();
    case (rw.kind)
      OP_WR: begin
        csr_we_i    <= 1'b1;
        csr_addr_i  <= rw.csr;
        csr_wdata_i <= rw.data;
      end
      OP_RD: begin
        csr_addr_i <= rw.csr;
        @(negedge clk);
        check_word("csr_rdata_o", rw.data, csr_rdata_o);
      end
      OP_ACC: begin
        req_valid_i   <= rw.vld;
        req_priv_i    <= rw.priv;
        req_addr_i    <= rw.addr;
        req_type_i[0] <= rw.typ0;
        req_type_i[1] <= rw.typ1;
        ex.vld        = rw.vld;
        ex.err        = rw.err;
        ex.t_issue    = $time;
        exp_q.push_back(ex);
      end
      OP_CLR: begin
        fault_clr_i <= 1'b1;
      end
      default: begin
        @(negedge clk);
        check_flag("fault_pending_o", rw.pend, fault_pending_o);
        check_word("fault_addr_o", rw.data, fault_addr_o);
        check_type("fault_type_o", rw.typ0, fault_type_o);
        check_chan("fault_chan_o", rw.chan, fault_chan_o);
      end
    endcase
    if (!rw.back) begin
      @(posedge clk);
      drive_idle();
      drain_responses();
    end
  endtask

  // Responses are checked at the falling edge
  always @(negedge clk) begin
    if (!rst_i && rsp_valid_o != '0) begin
      if (exp_q.size() == 0) begin
        $display("Response at %0t with no request outstanding", $time);
        n_other++;
      end else begin
        rsp_exp = exp_q.pop_front();
        check_valid(rsp_exp.vld, rsp_valid_o);
        check_err("rsp_err_o", rsp_exp.err, rsp_err_o);
        // Request was held during the cycle before its sampling edge
        lat_cyc = ($time - rsp_exp.t_issue - CLK_PERIOD / 2) / CLK_PERIOD;
        if (lat_cyc != RSP_LATENCY) begin
          $display("Response at %0t came %0d cycles after its request, not %0d",
                   $time, lat_cyc, RSP_LATENCY);
          n_other++;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    int n;
    int r;
    $timeformat(-9, 0, " ns", 0);
    csr_we_i    = 1'b0;
    csr_addr_i  = '0;
    csr_wdata_i = '0;
    req_valid_i = '0;
    req_addr_i  = '0;
    req_type_i  = '{default: ACC_READ};
    req_priv_i  = '0;
    fault_clr_i = 1'b0;
    void'($urandom(SEED));
    build_table();

    n = 0;
    while (rst_i !== 1'b0 && n < TIMEOUT_CYC) begin
      @(posedge clk);
      n++;
    end
    if (rst_i !== 1'b0) begin
      $display("Reset was never released");
      n_timeouts++;
    end

    r = 0;
    while (r < rows.size() && n_timeouts == 0) begin
      apply_row(rows[r]);
      r++;
    end
    @(posedge clk);
    drive_idle();
    drain_responses();
    // Catch stray responses
    repeat (4) @(posedge clk);

    $display("Checks: %0d, value errors: %0d, other errors: %0d, timeouts: %0d",
             n_checks, n_errors, n_other, n_timeouts);
    if (n_errors == 0 && n_other == 0 && n_timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: verif/tb_clk_gen.sv
// ----------------------------------------------------------------------
// Testbench clock and reset
// 100 ns clock, synchronous reset held for two rising edges
// ----------------------------------------------------------------------

`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  localparam int HALF_PERIOD = 50;
  localparam int RST_CYCLES  = 2;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Released right after the second edge
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

// File: hw/pmp_top.sv
// ---------------------------------------------------------------------
// PMP unit top level
// CSR block, region checker and fault log behind plain core ports
// ---------------------------------------------------------------------

`timescale 1ns/10ps

module pmp_top import pmp_pkg::*; (
  input  logic                            clk,
  input  logic                            rst_i,
  // CSR access
  input  logic                            csr_we_i,
  input  csr_addr_t                       csr_addr_i,
  input  logic [31:0]                     csr_wdata_i,
  output logic [31:0]                     csr_rdata_o,
  // Fetch and load/store check requests
  input  logic [PMP_CHANNELS-1:0]         req_valid_i,
  input  logic [PMP_CHANNELS-1:0][ADDR_W-1:0] req_addr_i,
  input  acc_type_t                       req_type_i [PMP_CHANNELS],
  input  logic [PMP_CHANNELS-1:0]         req_priv_i,
  // Responses, two cycles after the request
  output logic [PMP_CHANNELS-1:0]         rsp_valid_o,
  output logic [PMP_CHANNELS-1:0]         rsp_err_o,
  // First fault for the trap logic
  input  logic                            fault_clr_i,
  output logic                            fault_pending_o,
  output logic [ADDR_W-1:0]               fault_addr_o,
  output acc_type_t                       fault_type_o,
  output chan_idx_t                       fault_chan_o
);

  pmp_cfg_t  pmp_cfg  [PMP_ENTRIES];
  pmp_addr_t pmp_addr [PMP_ENTRIES];

  pmp_chk_if chk_bus ();

  pmp_csr_regs u_csr_regs (
    .clk         (clk),
    .rst_i       (rst_i),
    .csr_we_i    (csr_we_i),
    .csr_addr_i  (csr_addr_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .pmp_cfg_o   (pmp_cfg),
    .pmp_addr_o  (pmp_addr)
  );

  pmp_region_check u_region_check (
    .clk         (clk),
    .rst_i       (rst_i),
    .pmp_cfg_i   (pmp_cfg),
    .pmp_addr_i  (pmp_addr),
    .req_valid_i (req_valid_i),
    .req_addr_i  (req_addr_i),
    .req_type_i  (req_type_i),
    .req_priv_i  (req_priv_i),
    .chk         (chk_bus.check)
  );

  pmp_fault_log u_fault_log (
    .clk             (clk),
    .rst_i           (rst_i),
    .chk             (chk_bus.log),
    .fault_clr_i     (fault_clr_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_err_o       (rsp_err_o),
    .fault_pending_o (fault_pending_o),
    .fault_addr_o    (fault_addr_o),
    .fault_type_o    (fault_type_o),
    .fault_chan_o    (fault_chan_o)
  );

endmodule

// File: hw/pmp_fault_log.sv
// ---------------------------------------------------------------------
// PMP fault log
// Response strobes and a first-fault capture for the trap logic
// ---------------------------------------------------------------------

`timescale 1ns/10ps

module pmp_fault_log import pmp_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_i,
  pmp_chk_if.log                  chk,
  input  logic                    fault_clr_i,
  output logic [PMP_CHANNELS-1:0] rsp_valid_o,
  output logic [PMP_CHANNELS-1:0] rsp_err_o,
  output logic                    fault_pending_o,
  output logic [ADDR_W-1:0]       fault_addr_o,
  output acc_type_t               fault_type_o,
  output chan_idx_t               fault_chan_o
);

  logic [PMP_CHANNELS-1:0] err_hit;
  logic                    cap_hit;
  chan_idx_t               cap_chan;
  logic                    cap_en;

  assign err_hit = chk.chk_valid & chk.chk_err;

  // Pick the faulting channel, channel 0 has priority
  always_comb begin
    cap_hit  = 1'b0;
    cap_chan = '0;
    for (int c = PMP_CHANNELS - 1; c >= 0; c--) begin
      if (err_hit[c]) begin
        cap_hit  = 1'b1;
        cap_chan = chan_idx_t'(c);
      end
    end
  end

  // A fault in the clear cycle is still taken
  assign cap_en = cap_hit && (!fault_pending_o || fault_clr_i);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rsp_valid_o     <= '0;
      rsp_err_o       <= '0;
      fault_pending_o <= 1'b0;
      fault_addr_o    <= '0;
      fault_type_o    <= '0;
      fault_chan_o    <= '0;
    end else begin
      // Every check is answered exactly once
      rsp_valid_o <= chk.chk_valid;
      rsp_err_o   <= err_hit;

      if (cap_en) begin
        fault_pending_o <= 1'b1;
        fault_addr_o    <= chk.chk_addr[cap_chan];
        fault_type_o    <= chk.chk_type[cap_chan];
        fault_chan_o    <= cap_chan;
      end else if (fault_clr_i) begin
        fault_pending_o <= 1'b0;
      end
    end
  end

endmodule

// File: hw/pmp_region_check.sv
// ---------------------------------------------------------------------
// PMP region checker
// Matches each channel against all entries and registers a fault flag
// ---------------------------------------------------------------------

`timescale 1ns/10ps

module pmp_region_check import pmp_pkg::*; (
  input  logic                            clk,
  input  logic                            rst_i,
  input  pmp_cfg_t                        pmp_cfg_i  [PMP_ENTRIES],
  input  pmp_addr_t                       pmp_addr_i [PMP_ENTRIES],
  input  logic [PMP_CHANNELS-1:0]         req_valid_i,
  input  logic [PMP_CHANNELS-1:0][ADDR_W-1:0] req_addr_i,
  input  acc_type_t                       req_type_i [PMP_CHANNELS],
  input  logic [PMP_CHANNELS-1:0]         req_priv_i,
  pmp_chk_if.check                        chk
);

  logic [1:0]             entry_mode   [PMP_ENTRIES];
  logic [PMP_ENTRIES-1:0] entry_on;
  pmp_addr_t              trail_ones   [PMP_ENTRIES];
  pmp_addr_t              napot_mask   [PMP_ENTRIES];
  pmp_addr_t              tor_base     [PMP_ENTRIES];
  pmp_addr_t              req_word     [PMP_CHANNELS];
  logic [PMP_ENTRIES-1:0] region_match [PMP_CHANNELS];
  logic [PMP_ENTRIES-1:0] region_perm  [PMP_CHANNELS];
  logic [PMP_ENTRIES-1:0] region_ok    [PMP_CHANNELS];
  logic [PMP_CHANNELS-1:0] err_d;

  // ---------------------------------------------------------------------
  // Per-entry region bounds
  // ---------------------------------------------------------------------

  for (genvar e = 0; e < PMP_ENTRIES; e++) begin : g_entry
    assign entry_mode[e] = pmp_cfg_i[e][CFG_A_LO +: 2];
    assign entry_on[e]   = (entry_mode[e] != MODE_OFF);

    // NAPOT, yyy0111 covers the trailing ones plus the lowest zero
    assign trail_ones[e] = pmp_addr_i[e] & ~(pmp_addr_i[e] + 1'b1);
    assign napot_mask[e] = ~(trail_ones[e] | (trail_ones[e] + 1'b1));

    // TOR lower bound is the previous pmpaddr, zero for entry 0
    if (e == 0) begin : g_first
      assign tor_base[e] = '0;
    end else begin : g_rest
      assign tor_base[e] = pmp_addr_i[e-1];
    end
  end

  // Word address in pmpaddr units, grain is 4 bytes
  for (genvar c = 0; c < PMP_CHANNELS; c++) begin : g_word
    assign req_word[c] = {2'b00, req_addr_i[c][ADDR_W-1:2]};
  end

  // ---------------------------------------------------------------------
  // Match and permission per channel and entry
  // ---------------------------------------------------------------------

  always_comb begin
    for (int c = 0; c < PMP_CHANNELS; c++) begin
      for (int e = 0; e < PMP_ENTRIES; e++) begin
        case (entry_mode[e])
          // Upper bound exclusive
          MODE_TOR:   region_match[c][e] = (req_word[c] >= tor_base[e]) &&
                                           (req_word[c] < pmp_addr_i[e]);
          MODE_NA4:   region_match[c][e] = (req_word[c] == pmp_addr_i[e]);
          MODE_NAPOT: region_match[c][e] =
                        ((req_word[c] ^ pmp_addr_i[e]) & napot_mask[e]) == '0;
          default:    region_match[c][e] = 1'b0;
        endcase

        // RWX bit for this access type
        region_perm[c][e] = ((req_type_i[c] == ACC_READ)  && pmp_cfg_i[e][CFG_R]) ||
                            ((req_type_i[c] == ACC_WRITE) && pmp_cfg_i[e][CFG_W]) ||
                            ((req_type_i[c] == ACC_EXEC)  && pmp_cfg_i[e][CFG_X]);

        // Machine mode is bound only by locked entries
        region_ok[c][e] = region_perm[c][e] ||
                          (!req_priv_i[c] && !pmp_cfg_i[e][CFG_L]);
      end
    end
  end

  // Lowest matching entry wins, so scan from the top down
  always_comb begin
    for (int c = 0; c < PMP_CHANNELS; c++) begin
      // No match: deny user mode once any entry is active
      err_d[c] = req_priv_i[c] && (|entry_on);
      for (int e = PMP_ENTRIES - 1; e >= 0; e--) begin
        if (region_match[c][e]) begin
          err_d[c] = !region_ok[c][e];
        end
      end
    end
  end

  // ---------------------------------------------------------------------
  // Result registers
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst_i) begin
      chk.chk_valid <= '0;
    end else begin
      chk.chk_valid <= req_valid_i;
    end
  end

  // Payload, only looked at while chk_valid is high
  always_ff @(posedge clk) begin
    chk.chk_err  <= err_d;
    chk.chk_addr <= req_addr_i;
    for (int c = 0; c < PMP_CHANNELS; c++) begin
      chk.chk_type[c] <= req_type_i[c];
    end
  end

endmodule

// File: hw/pmp_csr_regs.sv
// ---------------------------------------------------------------------
// PMP CSR registers
// Holds pmpcfg/pmpaddr entries, applies lock rules, provides read-back
// ---------------------------------------------------------------------

`timescale 1ns/10ps

module pmp_csr_regs import pmp_pkg::*; (
  input  logic        clk,
  input  logic        rst_i,
  input  logic        csr_we_i,
  input  csr_addr_t   csr_addr_i,
  input  logic [31:0] csr_wdata_i,
  output logic [31:0] csr_rdata_o,
  output pmp_cfg_t    pmp_cfg_o  [PMP_ENTRIES],
  output pmp_addr_t   pmp_addr_o [PMP_ENTRIES]
);

  pmp_cfg_t                cfg_q     [PMP_ENTRIES];
  pmp_addr_t               addr_q    [PMP_ENTRIES];
  pmp_cfg_t                cfg_wbyte [PMP_ENTRIES];
  logic [PMP_ENTRIES-1:0]  cfg_hit;
  logic [PMP_ENTRIES-1:0]  addr_hit;
  logic [PMP_ENTRIES-1:0]  tor_lock;

  // Reserved bits 6:5 read as zero, W needs R
  function automatic pmp_cfg_t legalize_cfg(input pmp_cfg_t wr);
    pmp_cfg_t cfg;
    cfg          = wr;
    cfg[6:5]     = 2'b00;
    cfg[CFG_W]   = wr[CFG_W] & wr[CFG_R];
    return cfg;
  endfunction

  // ---------------------------------------------------------------------
  // Write decode
  // ---------------------------------------------------------------------

  for (genvar e = 0; e < PMP_ENTRIES; e++) begin : g_dec
    // Entry e lives in byte (e % 4) of pmpcfg(e / 4)
    assign cfg_hit[e]   = csr_we_i &&
                          (csr_addr_i == csr_addr_t'(CSR_PMPCFG0 + e / CFG_PER_REG));
    assign addr_hit[e]  = csr_we_i && (csr_addr_i == csr_addr_t'(CSR_PMPADDR0 + e));
    assign cfg_wbyte[e] = csr_wdata_i[8*(e % CFG_PER_REG) +: 8];

    // A locked TOR entry also freezes the base address below it
    if (e == PMP_ENTRIES - 1) begin : g_last
      assign tor_lock[e] = 1'b0;
    end else begin : g_next
      assign tor_lock[e] = cfg_q[e+1][CFG_L] &&
                           (cfg_q[e+1][CFG_A_LO +: 2] == MODE_TOR);
    end
  end

  // ---------------------------------------------------------------------
  // Entry storage
  // ---------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int e = 0; e < PMP_ENTRIES; e++) begin
        cfg_q[e]  <= '0;
        addr_q[e] <= '0;
      end
    end else begin
      for (int e = 0; e < PMP_ENTRIES; e++) begin
        // Locked entries ignore both cfg and addr writes
        if (cfg_hit[e] && !cfg_q[e][CFG_L]) begin
          cfg_q[e] <= legalize_cfg(cfg_wbyte[e]);
        end
        if (addr_hit[e] && !cfg_q[e][CFG_L] && !tor_lock[e]) begin
          addr_q[e] <= csr_wdata_i;
        end
      end
    end
  end

  // Read-back, zero for unmapped addresses incl. pmpcfg2/3
  always_comb begin
    csr_rdata_o = '0;
    for (int r = 0; r < CFG_REGS; r++) begin
      if (csr_addr_i == csr_addr_t'(CSR_PMPCFG0 + r)) begin
        for (int b = 0; b < CFG_PER_REG; b++) begin
          csr_rdata_o[8*b +: 8] = cfg_q[r*CFG_PER_REG + b];
        end
      end
    end
    for (int e = 0; e < PMP_ENTRIES; e++) begin
      if (csr_addr_i == csr_addr_t'(CSR_PMPADDR0 + e)) begin
        csr_rdata_o = addr_q[e];
      end
    end
  end

  assign pmp_cfg_o  = cfg_q;
  assign pmp_addr_o = addr_q;

endmodule

// File: hw/pmp_chk_if.sv
// ---------------------------------------------------------------------
// PMP check result bus
// Registered per-channel decisions from the checker to the fault log
// ---------------------------------------------------------------------

`timescale 1ns/10ps

interface pmp_chk_if import pmp_pkg::*; ();

  // One-cycle strobe per channel, qualifies the fields below
  logic [PMP_CHANNELS-1:0]             chk_valid;
  // Access must fault
  logic [PMP_CHANNELS-1:0]             chk_err;
  // Access address and type, carried along for the fault log
  logic [PMP_CHANNELS-1:0][ADDR_W-1:0] chk_addr;
  acc_type_t                           chk_type [PMP_CHANNELS];

  // Region checker side
  modport check (output chk_valid, chk_err, chk_addr, chk_type);

  // Fault log side
  modport log (input chk_valid, chk_err, chk_addr, chk_type);

endinterface

// File: hw/pmp_pkg.sv
// ---------------------------------------------------------------------
// PMP shared definitions
// Entry counts, CSR map, config bit layout, mode and access codes
// ---------------------------------------------------------------------

package pmp_pkg;

  // ---------------------------------------------------------------------
  // Counts and widths
  // ---------------------------------------------------------------------

  // Eight entries, grain fixed at 4 bytes
  localparam int PMP_ENTRIES  = 8;
  // Channel 0 is fetch, channel 1 is load/store
  localparam int PMP_CHANNELS = 2;
  localparam int ADDR_W       = 32;

  // Four config bytes per pmpcfg register
  localparam int CFG_PER_REG  = 4;
  localparam int CFG_REGS     = PMP_ENTRIES / CFG_PER_REG;

  // ---------------------------------------------------------------------
  // Typedefs
  // ---------------------------------------------------------------------

  // One entry configuration byte {L, 0, 0, A[1:0], X, W, R}
  typedef logic [7:0]  pmp_cfg_t;
  // pmpaddr word, holds byte address bits 33 to 2
  typedef logic [31:0] pmp_addr_t;
  typedef logic [1:0]  acc_type_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [$clog2(PMP_CHANNELS)-1:0] chan_idx_t;

  // ---------------------------------------------------------------------
  // CSR map
  // ---------------------------------------------------------------------

  // pmpcfg1 follows at 0x3A1, pmpcfg2/3 are not implemented
  localparam csr_addr_t CSR_PMPCFG0  = 12'h3A0;
  // pmpaddr0..7 are consecutive from here
  localparam csr_addr_t CSR_PMPADDR0 = 12'h3B0;

  // Bit positions inside a config byte
  localparam int CFG_R    = 0;
  localparam int CFG_W    = 1;
  localparam int CFG_X    = 2;
  // Low bit of the 2-bit A field
  localparam int CFG_A_LO = 3;
  localparam int CFG_L    = 7;

  // Address matching modes
  localparam logic [1:0] MODE_OFF   = 2'd0;
  localparam logic [1:0] MODE_TOR   = 2'd1;
  localparam logic [1:0] MODE_NA4   = 2'd2;
  localparam logic [1:0] MODE_NAPOT = 2'd3;

  // Access types
  localparam acc_type_t ACC_READ  = 2'd0;
  localparam acc_type_t ACC_WRITE = 2'd1;
  localparam acc_type_t ACC_EXEC  = 2'd2;

endpackage
